// File: Bender.yml
package:
  name: pool_engine

sources:
  - files:
      - source/pool_pkg.sv
      - source/pool_map_if.sv
      - source/pool_map_arbiter.sv
      - source/pool_core_ctrl.sv
      - source/pool_max_lanes.sv
      - source/pool_core.sv
      - source/pool_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/pool_tb.sv

// File: bench/pool_tb_tests.svh
`ifndef POOL_TB_TESTS_SVH
`define POOL_TB_TESTS_SVH

// ==============================
// Model and job helpers
// ==============================
// Lane-wise unsigned max over the listed neighbors
function automatic feat_t expect_result(input int c, input int r);
    int        p;
    int        g;
    map_word_t w;
    idx_t      nb;
    feat_t     f;
    feat_t     m;
    p = r / job_grp[c];
    g = r % job_grp[c];
    w = mmem[(job_map_base[c] + p) % 256];
    m = '0;
    for (int i = 0; i < job_k[c]; i++) begin
        nb = w[i*IDX_WIDTH +: IDX_WIDTH];
        f  = fmem[c][(nb * job_grp[c] + g) % FMEM_DEPTH];
        for (int l = 0; l < POOL_LANES; l++) begin
            if (f[l*ACT_WIDTH +: ACT_WIDTH] > m[l*ACT_WIDTH +: ACT_WIDTH]) begin
                m[l*ACT_WIDTH +: ACT_WIDTH] = f[l*ACT_WIDTH +: ACT_WIDTH];
            end
        end
    end
    return m;
endfunction

// Neighbor indices 0 to 15 in every slot
task automatic fill_map(input int base, input int nip);
    for (int p = 0; p < nip; p++) begin
        for (int i = 0; i < K_MAX; i++) begin
            mmem[(base + p) % 256][i*IDX_WIDTH +: IDX_WIDTH] = idx_t'(rand_bits(4));
        end
    end
endtask

task automatic set_job(input int c, input int k, input int nip, input int grp,
                       input int map_base, input int out_base);
    job_k[c]        = k;
    job_nip[c]      = nip;
    job_grp[c]      = grp;
    job_map_base[c] = map_base;
    job_out_base[c] = out_base;
    cfg_k[c*K_WIDTH +: K_WIDTH]            = k_t'(k);
    cfg_nip[c*IDX_WIDTH +: IDX_WIDTH]      = idx_t'(nip);
    cfg_chn_grp[c*GRP_WIDTH +: GRP_WIDTH]  = grp_t'(grp);
    cfg_map_base[c*IDX_WIDTH +: IDX_WIDTH] = idx_t'(map_base);
    cfg_out_base[c*IDX_WIDTH +: IDX_WIDTH] = idx_t'(out_base);
endtask

// Config handshake on the cores in mask
task automatic start_jobs(input logic [NUM_CORES-1:0] mask);
    logic [NUM_CORES-1:0] hs;
    @(posedge clk);
    #2;
    cfg_valid = mask;
    for (int c = 0; c < NUM_CORES; c++) begin
        if (mask[c]) begin
            wr_cnt[c] = 0;
        end
    end
    while (cfg_valid != '0) begin
        @(negedge clk);
        hs = cfg_valid & cfg_ready;
        @(posedge clk);
        #2;
        cfg_valid = cfg_valid & ~hs;
    end
    // Busy and requesting a map word next cycle
    @(negedge clk);
    check_value("cfg_ready after accept", cfg_ready & mask, '0);
    check_value("map request after accept", map_addr_valid, 1'b1);
endtask

task automatic wait_done(input int c);
    while (!cfg_ready[c]) begin
        @(negedge clk);
    end
    check_value("number of writes", wr_cnt[c], job_nip[c] * job_grp[c]);
endtask

task automatic run_single(input int c, input int k, input int nip, input int grp,
                          input int map_base, input int out_base);
    set_job(c, k, nip, grp, map_base, out_base);
    start_jobs(NUM_CORES'(1) << c);
    wait_done(c);
endtask

// ==============================
// Directed tests
// ==============================
task automatic reset_state_check();
    @(negedge clk);
    check_value("cfg_ready after reset", cfg_ready, 2'b11);
    check_value("map_addr_valid after reset", map_addr_valid, 1'b0);
    check_value("ofm_rd_addr_valid after reset", ofm_rd_addr_valid, 2'b00);
    check_value("ofm_wr_valid after reset", ofm_wr_valid, 2'b00);
    check_value("ofm_rd_ready after reset", ofm_rd_ready, 2'b11);
endtask

task automatic single_neighbor_job();
    fill_map(16'h10, 2);
    run_single(0, 1, 2, 3, 16'h10, 16'h040);
endtask

// Map rows kept for the back-pressure rerun
task automatic full_neighbor_job();
    fill_map(16'h20, 4);
    run_single(0, 8, 4, 2, 16'h20, 16'h100);
endtask

// Both cores accepted in the same cycle
task automatic dual_core_job();
    fill_map(16'h40, 3);
    fill_map(16'h60, 2);
    set_job(0, 4, 3, 2, 16'h40, 16'h300);
    set_job(1, 5, 2, 3, 16'h60, 16'h380);
    start_jobs(2'b11);
    wait_done(0);
    wait_done(1);
endtask

task automatic backpressure_job();
    bp_on = 1'b1;
    run_single(0, 8, 4, 2, 16'h20, 16'h200);
    bp_on = 1'b0;
    for (int r = 0; r < 8; r++) begin
        check_value("result under back-pressure", out_mem[0][10'h200 + r],
                    out_mem[0][10'h100 + r]);
    end
endtask

`endif

// File: bench/pool_tb.sv
`default_nettype none

module pool_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import pool_pkg::*;

    localparam int NUM_CORES  = 2;
    localparam int FMEM_DEPTH = 256;
    localparam int PEND_DEPTH = 256;
    // Feature reads of all jobs in tests 2 to 5
    localparam int FEAT_READS     = 6 + 64 + 24 + 30 + 64;
    localparam int TIMEOUT_CYCLES = FEAT_READS * 4 + 2000;

    logic                             clk;
    logic                             rst_n;
    logic [NUM_CORES-1:0]             cfg_valid;
    logic [NUM_CORES-1:0]             cfg_ready;
    logic [NUM_CORES*K_WIDTH-1:0]     cfg_k;
    logic [NUM_CORES*IDX_WIDTH-1:0]   cfg_nip;
    logic [NUM_CORES*GRP_WIDTH-1:0]   cfg_chn_grp;
    logic [NUM_CORES*IDX_WIDTH-1:0]   cfg_map_base;
    logic [NUM_CORES*IDX_WIDTH-1:0]   cfg_out_base;
    idx_t                             map_addr;
    logic                             map_addr_valid;
    logic                             map_addr_ready;
    logic                             map_rsp_valid;
    map_word_t                        map_rsp_data;
    logic [NUM_CORES*IDX_WIDTH-1:0]   ofm_rd_addr;
    logic [NUM_CORES-1:0]             ofm_rd_addr_valid;
    logic [NUM_CORES-1:0]             ofm_rd_addr_ready;
    logic [NUM_CORES*FEAT_WIDTH-1:0]  ofm_rd_data;
    logic [NUM_CORES-1:0]             ofm_rd_valid;
    logic [NUM_CORES-1:0]             ofm_rd_ready;
    logic [NUM_CORES*IDX_WIDTH-1:0]   ofm_wr_addr;
    logic [NUM_CORES*FEAT_WIDTH-1:0]  ofm_wr_data;
    logic [NUM_CORES-1:0]             ofm_wr_valid;
    logic [NUM_CORES-1:0]             ofm_wr_ready;

    // Memory models
    map_word_t mmem [256];
    feat_t     fmem [NUM_CORES][FMEM_DEPTH];
    feat_t     out_mem [NUM_CORES][1024];

    // In-order read return with one ring per core
    idx_t      pend [NUM_CORES][PEND_DEPTH];
    int        wp [NUM_CORES];
    int        rp [NUM_CORES];

    // Job bookkeeping for the model
    int        job_k [NUM_CORES];
    int        job_nip [NUM_CORES];
    int        job_grp [NUM_CORES];
    int        job_map_base [NUM_CORES];
    int        job_out_base [NUM_CORES];
    int        wr_cnt [NUM_CORES];
    logic [NUM_CORES-1:0] ready_due;

    logic        bp_on;
    logic        map_hs;
    idx_t        map_hs_addr;
    int          cycle_cnt;
    logic [31:0] lfsr_state = 32'h5bba_2260;

    pool_top #(
        .POOL_CORE (NUM_CORES)
    ) pool_top_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .cfg_valid         (cfg_valid),
        .cfg_ready         (cfg_ready),
        .cfg_k             (cfg_k),
        .cfg_nip           (cfg_nip),
        .cfg_chn_grp       (cfg_chn_grp),
        .cfg_map_base      (cfg_map_base),
        .cfg_out_base      (cfg_out_base),
        .map_addr          (map_addr),
        .map_addr_valid    (map_addr_valid),
        .map_addr_ready    (map_addr_ready),
        .map_rsp_valid     (map_rsp_valid),
        .map_rsp_data      (map_rsp_data),
        .ofm_rd_addr       (ofm_rd_addr),
        .ofm_rd_addr_valid (ofm_rd_addr_valid),
        .ofm_rd_addr_ready (ofm_rd_addr_ready),
        .ofm_rd_data       (ofm_rd_data),
        .ofm_rd_valid      (ofm_rd_valid),
        .ofm_rd_ready      (ofm_rd_ready),
        .ofm_wr_addr       (ofm_wr_addr),
        .ofm_wr_data       (ofm_wr_data),
        .ofm_wr_valid      (ofm_wr_valid),
        .ofm_wr_ready      (ofm_wr_ready)
    );

    // ==============================
    // Clock, LFSR, check
    // ==============================
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("ERR %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Output write collector checked against the model
    task automatic collect_write(input int c);
        idx_t  addr;
        feat_t data;
        addr = ofm_wr_addr[c*IDX_WIDTH +: IDX_WIDTH];
        data = ofm_wr_data[c*FEAT_WIDTH +: FEAT_WIDTH];
        check_value("write within job", wr_cnt[c] < job_nip[c] * job_grp[c], 1'b1);
        check_value("write address", addr, idx_t'(job_out_base[c] + wr_cnt[c]));
        check_value("write data", data, expect_result(c, wr_cnt[c]));
        out_mem[c][addr[9:0]] = data;
        wr_cnt[c]++;
        if (wr_cnt[c] == job_nip[c] * job_grp[c]) begin
            ready_due[c] = 1'b1;
        end
    endtask

    // ==============================
    // Bus models
    // ==============================
    // Sample at the falling edge, drive 2 ns after the rising edge
    always begin
        @(negedge clk);
        map_hs      = map_addr_valid && map_addr_ready;
        map_hs_addr = map_addr;
        for (int c = 0; c < NUM_CORES; c++) begin
            if (ofm_rd_addr_valid[c] && ofm_rd_addr_ready[c]) begin
                pend[c][wp[c]] = ofm_rd_addr[c*IDX_WIDTH +: IDX_WIDTH];
                wp[c] = (wp[c] + 1) % PEND_DEPTH;
            end
            if (ofm_rd_valid[c] && ofm_rd_ready[c]) begin
                rp[c] = (rp[c] + 1) % PEND_DEPTH;
            end
            // Job end one cycle after the last write
            if (ready_due[c]) begin
                check_value("cfg_ready after last write", cfg_ready[c], 1'b1);
                ready_due[c] = 1'b0;
            end
            if (ofm_wr_valid[c] && ofm_wr_ready[c]) begin
                collect_write(c);
            end
        end
        @(posedge clk);
        #2;
        // Map answer one cycle after the address
        map_rsp_valid = map_hs;
        map_rsp_data  = map_hs ? mmem[map_hs_addr[7:0]] : '0;
        for (int c = 0; c < NUM_CORES; c++) begin
            ofm_rd_valid[c] = (wp[c] != rp[c]);
            ofm_rd_data[c*FEAT_WIDTH +: FEAT_WIDTH] =
                (wp[c] != rp[c]) ? fmem[c][pend[c][rp[c]][7:0]] : '0;
            ofm_rd_addr_ready[c] = bp_on ? next_bit() : 1'b1;
            ofm_wr_ready[c]      = bp_on ? next_bit() : 1'b1;
        end
        map_addr_ready = bp_on ? next_bit() : 1'b1;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $fatal(1, "Timeout");
        end
    end

    `include "pool_tb_tests.svh"

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        rst_n          = 1'b0;
        cfg_valid      = '0;
        cfg_k          = '0;
        cfg_nip        = '0;
        cfg_chn_grp    = '0;
        cfg_map_base   = '0;
        cfg_out_base   = '0;
        map_addr_ready = 1'b1;
        map_rsp_valid  = 1'b0;
        map_rsp_data   = '0;
        ofm_rd_addr_ready = '1;
        ofm_rd_data    = '0;
        ofm_rd_valid   = '0;
        ofm_wr_ready   = '1;
        bp_on          = 1'b0;
        ready_due      = '0;
        cycle_cnt      = 0;
        for (int c = 0; c < NUM_CORES; c++) begin
            wp[c]     = 0;
            rp[c]     = 0;
            wr_cnt[c] = 0;
            for (int a = 0; a < FMEM_DEPTH; a++) begin
                fmem[c][a] = rand_bits(32);
            end
        end
        for (int a = 0; a < 256; a++) begin
            mmem[a] = '0;
        end
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;

        reset_state_check();
        single_neighbor_job();
        full_neighbor_job();
        dual_core_job();
        backpressure_job();
        repeat (4) @(posedge clk);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+bench
source/pool_pkg.sv
source/pool_map_if.sv
source/pool_map_arbiter.sv
source/pool_core_ctrl.sv
source/pool_max_lanes.sv
source/pool_core.sv
source/pool_top.sv
bench/pool_tb.sv

// File: source/pool_core.sv
`default_nettype none

module pool_core (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cfg_valid,
    output logic            cfg_ready,
    input  pool_pkg::k_t    cfg_k,
    input  pool_pkg::idx_t  cfg_nip,
    input  pool_pkg::grp_t  cfg_chn_grp,
    input  pool_pkg::idx_t  cfg_map_base,
    input  pool_pkg::idx_t  cfg_out_base,
    pool_map_if.core        map,
    output pool_pkg::idx_t  ofm_rd_addr,
    output logic            ofm_rd_addr_valid,
    input  logic            ofm_rd_addr_ready,
    input  pool_pkg::feat_t ofm_rd_data,
    input  logic            ofm_rd_valid,
    output logic            ofm_rd_ready,
    output pool_pkg::idx_t  ofm_wr_addr,
    output pool_pkg::feat_t ofm_wr_data,
    output logic            ofm_wr_valid,
    input  logic            ofm_wr_ready
);
    import pool_pkg::*;

    // Job parameters for the lanes
    k_t   k;
    idx_t result_total;
    idx_t out_base;
    // Last write accepted
    logic done;

    pool_core_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_valid     (cfg_valid),
        .cfg_ready     (cfg_ready),
        .cfg_k         (cfg_k),
        .cfg_nip       (cfg_nip),
        .cfg_chn_grp   (cfg_chn_grp),
        .cfg_map_base  (cfg_map_base),
        .cfg_out_base  (cfg_out_base),
        .map           (map),
        .rd_addr       (ofm_rd_addr),
        .rd_addr_valid (ofm_rd_addr_valid),
        .rd_addr_ready (ofm_rd_addr_ready),
        .k             (k),
        .result_total  (result_total),
        .out_base      (out_base),
        .done          (done)
    );

    pool_max_lanes u_lanes (
        .clk          (clk),
        .rst_n        (rst_n),
        .k            (k),
        .result_total (result_total),
        .out_base     (out_base),
        .rd_data      (ofm_rd_data),
        .rd_valid     (ofm_rd_valid),
        .rd_ready     (ofm_rd_ready),
        .wr_addr      (ofm_wr_addr),
        .wr_data      (ofm_wr_data),
        .wr_valid     (ofm_wr_valid),
        .wr_ready     (ofm_wr_ready),
        .done         (done)
    );

endmodule

`default_nettype wire

// File: source/pool_core_ctrl.sv
`default_nettype none

module pool_core_ctrl (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           cfg_valid,
    output logic           cfg_ready,
    input  pool_pkg::k_t   cfg_k,
    input  pool_pkg::idx_t cfg_nip,
    input  pool_pkg::grp_t cfg_chn_grp,
    input  pool_pkg::idx_t cfg_map_base,
    input  pool_pkg::idx_t cfg_out_base,
    pool_map_if.core       map,
    output pool_pkg::idx_t rd_addr,
    output logic           rd_addr_valid,
    input  logic           rd_addr_ready,
    output pool_pkg::k_t   k,
    output pool_pkg::idx_t result_total,
    output pool_pkg::idx_t out_base,
    input  logic           done
);
    import pool_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic        busy;

    // Latched job
    k_t          k_q;
    idx_t        nip_q;
    grp_t        grp_q;
    idx_t        map_base_q;
    idx_t        out_base_q;
    idx_t        total_q;
    map_word_t   map_q;

    // Loop counters, point > group > neighbor
    k_t          nb_cnt;
    grp_t        grp_cnt;
    idx_t        pt_cnt;

    idx_t        nb_idx;
    logic        cfg_hs;
    logic        rd_hs;
    logic        last_nb;
    logic        last_grp;
    logic        last_pt;

    // ==============================
    // Handshakes and decode
    // ==============================
    // Ready only when idle and the lanes have drained
    assign cfg_ready     = (state == IDLE) && !busy;
    assign cfg_hs        = cfg_valid && cfg_ready;
    assign rd_addr_valid = (state == ISSUE);
    assign rd_hs         = rd_addr_valid && rd_addr_ready;

    assign last_nb  = (nb_cnt == k_q - 1'b1);
    assign last_grp = (grp_cnt == grp_q - 1'b1);
    assign last_pt  = (pt_cnt == nip_q - 1'b1);

    // Map word for the current point
    assign map.req  = (state == MAP_REQ);
    assign map.addr = map_base_q + pt_cnt;

    // Unpack neighbor, index * groups + group
    assign nb_idx  = map_q[nb_cnt*IDX_WIDTH +: IDX_WIDTH];
    assign rd_addr = idx_t'(nb_idx * grp_q) + idx_t'(grp_cnt);

    // To the max lanes
    assign k            = k_q;
    assign result_total = total_q;
    assign out_base     = out_base_q;

    // ==============================
    // FSM
    // ==============================
    always_comb begin
        next_state = state;
        case (state)
            IDLE:     if (cfg_hs) next_state = MAP_REQ;
            MAP_REQ:  if (map.grant) next_state = MAP_WAIT;
            MAP_WAIT: if (map.rsp_valid) next_state = ISSUE;
            ISSUE: begin
                // End of one point
                if (rd_hs && last_nb && last_grp) begin
                    next_state = last_pt ? IDLE : MAP_REQ;
                end
            end
            default:  next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            busy    <= 1'b0;
            nb_cnt  <= '0;
            grp_cnt <= '0;
            pt_cnt  <= '0;
        end else begin
            state <= next_state;
            // Job open until the last write is taken
            if (cfg_hs) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
            if (cfg_hs) begin
                nb_cnt  <= '0;
                grp_cnt <= '0;
                pt_cnt  <= '0;
            end else if (rd_hs) begin
                if (last_nb) begin
                    nb_cnt <= '0;
                    if (last_grp) begin
                        grp_cnt <= '0;
                        pt_cnt  <= pt_cnt + 1'b1;
                    end else begin
                        grp_cnt <= grp_cnt + 1'b1;
                    end
                end else begin
                    nb_cnt <= nb_cnt + 1'b1;
                end
            end
        end
    end

    // Config and map word capture
    always_ff @(posedge clk) begin
        if (cfg_hs) begin
            k_q        <= cfg_k;
            nip_q      <= cfg_nip;
            grp_q      <= cfg_chn_grp;
            map_base_q <= cfg_map_base;
            out_base_q <= cfg_out_base;
            total_q    <= idx_t'(cfg_nip * cfg_chn_grp);
        end
        if (map.rsp_valid) begin
            map_q <= map.rsp_data;
        end
    end

endmodule

`default_nettype wire

// File: source/pool_map_arbiter.sv
`default_nettype none

module pool_map_arbiter #(
    parameter int POOL_CORE = 2
) (
    input  logic                clk,
    input  logic                rst_n,
    pool_map_if.arb             map [POOL_CORE],
    output pool_pkg::idx_t      map_addr,
    output logic                map_addr_valid,
    input  logic                map_addr_ready,
    input  logic                map_rsp_valid,
    input  pool_pkg::map_word_t map_rsp_data
);
    import pool_pkg::*;

    // Owner select width, at least one bit
    localparam int SEL_WIDTH = (POOL_CORE > 1) ? $clog2(POOL_CORE) : 1;

    logic [POOL_CORE-1:0] req_vec;
    idx_t                 req_addr [POOL_CORE];
    logic [SEL_WIDTH-1:0] prio_sel;
    logic [SEL_WIDTH-1:0] sel;
    logic [SEL_WIDTH-1:0] lock_sel;
    logic                 locked;
    logic [SEL_WIDTH-1:0] owner;
    logic                 outstanding;
    logic                 addr_hs;

    // ==============================
    // Per-core fan in / fan out
    // ==============================
    for (genvar i = 0; i < POOL_CORE; i++) begin : g_port
        assign req_vec[i]       = map[i].req;
        assign req_addr[i]      = map[i].addr;
        assign map[i].grant     = addr_hs && (sel == SEL_WIDTH'(i));
        // Response goes only to the registered owner
        assign map[i].rsp_valid = map_rsp_valid && outstanding && (owner == SEL_WIDTH'(i));
        assign map[i].rsp_data  = map_rsp_data;
    end

    // Priority encoder, lowest index wins
    always_comb begin
        prio_sel = '0;
        for (int i = POOL_CORE - 1; i >= 0; i--) begin
            if (req_vec[i]) begin
                prio_sel = SEL_WIDTH'(i);
            end
        end
    end

    // Keep the address stable while stalled by the map port
    assign sel            = locked ? lock_sel : prio_sel;
    assign map_addr_valid = (|req_vec) && !outstanding;
    assign map_addr       = req_addr[sel];
    assign addr_hs        = map_addr_valid && map_addr_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= 1'b0;
            owner       <= '0;
            locked      <= 1'b0;
            lock_sel    <= '0;
        end else begin
            // Single read in flight
            if (addr_hs) begin
                outstanding <= 1'b1;
                owner       <= sel;
            end else if (map_rsp_valid) begin
                outstanding <= 1'b0;
            end
            locked   <= map_addr_valid && !map_addr_ready;
            lock_sel <= sel;
        end
    end

endmodule

`default_nettype wire

// File: source/pool_map_if.sv
`default_nettype none

// One core's path to the shared neighbor map
interface pool_map_if;
    import pool_pkg::*;

    // Request side, held until grant
    logic      req;
    idx_t      addr;
    // Accept strobe from the arbiter
    logic      grant;
    // One response pulse per grant
    logic      rsp_valid;
    map_word_t rsp_data;

    modport core (
        output req,
        output addr,
        input  grant,
        input  rsp_valid,
        input  rsp_data
    );

    modport arb (
        input  req,
        input  addr,
        output grant,
        output rsp_valid,
        output rsp_data
    );

endinterface

`default_nettype wire

// File: source/pool_max_lanes.sv
`default_nettype none

module pool_max_lanes (
    input  logic            clk,
    input  logic            rst_n,
    input  pool_pkg::k_t    k,
    input  pool_pkg::idx_t  result_total,
    input  pool_pkg::idx_t  out_base,
    input  pool_pkg::feat_t rd_data,
    input  logic            rd_valid,
    output logic            rd_ready,
    output pool_pkg::idx_t  wr_addr,
    output pool_pkg::feat_t wr_data,
    output logic            wr_valid,
    input  logic            wr_ready,
    output logic            done
);
    import pool_pkg::*;

    k_t   word_cnt;
    idx_t res_cnt;
    logic rd_hs;
    logic wr_hs;
    logic first_word;
    logic last_word;
    logic last_res;

    // Stall reads while a result waits, unless it leaves this cycle
    assign rd_ready   = !wr_valid || wr_ready;
    assign rd_hs      = rd_valid && rd_ready;
    assign wr_hs      = wr_valid && wr_ready;
    assign first_word = (word_cnt == '0);
    assign last_word  = (word_cnt == k - 1'b1);
    assign last_res   = (res_cnt == result_total - 1'b1);

    // Sequential output address
    assign wr_addr = out_base + res_cnt;
    assign done    = wr_hs && last_res;

    // ==============================
    // Lane compare
    // ==============================
    for (genvar lane = 0; lane < POOL_LANES; lane++) begin : g_lane
        act_t lane_in;
        act_t max_q;

        assign lane_in = rd_data[lane*ACT_WIDTH +: ACT_WIDTH];

        // First word loads, later words keep the larger (unsigned)
        always_ff @(posedge clk) begin
            if (rd_hs) begin
                max_q <= (first_word || (lane_in > max_q)) ? lane_in : max_q;
            end
        end

        assign wr_data[lane*ACT_WIDTH +: ACT_WIDTH] = max_q;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt <= '0;
            res_cnt  <= '0;
            wr_valid <= 1'b0;
        end else begin
            // Words of the current group
            if (rd_hs) begin
                word_cnt <= last_word ? '0 : word_cnt + 1'b1;
            end
            // Result held until written
            if (rd_hs && last_word) begin
                wr_valid <= 1'b1;
            end else if (wr_hs) begin
                wr_valid <= 1'b0;
            end
            // Wraps for the next job
            if (wr_hs) begin
                res_cnt <= last_res ? '0 : res_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/pool_pkg.sv
`default_nettype none

package pool_pkg;

    // ==============================
    // Widths
    // ==============================

    // Point, neighbor and memory index
    localparam int IDX_WIDTH  = 16;
    // One activation
    localparam int ACT_WIDTH  = 8;
    // Activations per feature word
    localparam int POOL_LANES = 4;
    // Neighbor slots in one map word
    localparam int K_MAX      = 8;
    // Neighbor count field, holds 1 to K_MAX
    localparam int K_WIDTH    = 4;
    // Channel-group field
    localparam int GRP_WIDTH  = 8;

    localparam int FEAT_WIDTH = POOL_LANES * ACT_WIDTH;
    localparam int MAP_WIDTH  = K_MAX * IDX_WIDTH;

    // ==============================
    // Types
    // ==============================

    typedef logic [IDX_WIDTH-1:0]  idx_t;
    typedef logic [ACT_WIDTH-1:0]  act_t;
    // Lane n at bits n*ACT_WIDTH
    typedef logic [FEAT_WIDTH-1:0] feat_t;
    // Neighbor i at bits i*IDX_WIDTH
    typedef logic [MAP_WIDTH-1:0]  map_word_t;
    typedef logic [K_WIDTH-1:0]    k_t;
    typedef logic [GRP_WIDTH-1:0]  grp_t;

    // Controller FSM
    typedef enum logic [1:0] {
        IDLE,
        MAP_REQ,
        MAP_WAIT,
        ISSUE
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: source/pool_top.sv
`default_nettype none

module pool_top #(
    parameter int POOL_CORE = 2
) (
    input  logic                                            clk,
    input  logic                                            rst_n,

    // Per-core configuration
    input  logic [POOL_CORE-1:0]                            cfg_valid,
    output logic [POOL_CORE-1:0]                            cfg_ready,
    input  logic [POOL_CORE*pool_pkg::K_WIDTH-1:0]          cfg_k,
    input  logic [POOL_CORE*pool_pkg::IDX_WIDTH-1:0]        cfg_nip,
    input  logic [POOL_CORE*pool_pkg::GRP_WIDTH-1:0]        cfg_chn_grp,
    input  logic [POOL_CORE*pool_pkg::IDX_WIDTH-1:0]        cfg_map_base,
    input  logic [POOL_CORE*pool_pkg::IDX_WIDTH-1:0]        cfg_out_base,

    // Shared map read port
    output pool_pkg::idx_t                                  map_addr,
    output logic                                            map_addr_valid,
    input  logic                                            map_addr_ready,
    input  logic                                            map_rsp_valid,
    input  pool_pkg::map_word_t                             map_rsp_data,

    // Per-core feature reads
    output logic [POOL_CORE*pool_pkg::IDX_WIDTH-1:0]        ofm_rd_addr,
    output logic [POOL_CORE-1:0]                            ofm_rd_addr_valid,
    input  logic [POOL_CORE-1:0]                            ofm_rd_addr_ready,
    input  logic [POOL_CORE*pool_pkg::FEAT_WIDTH-1:0]       ofm_rd_data,
    input  logic [POOL_CORE-1:0]                            ofm_rd_valid,
    output logic [POOL_CORE-1:0]                            ofm_rd_ready,

    // Per-core result writes
    output logic [POOL_CORE*pool_pkg::IDX_WIDTH-1:0]        ofm_wr_addr,
    output logic [POOL_CORE*pool_pkg::FEAT_WIDTH-1:0]       ofm_wr_data,
    output logic [POOL_CORE-1:0]                            ofm_wr_valid,
    input  logic [POOL_CORE-1:0]                            ofm_wr_ready
);
    import pool_pkg::*;

    // One map link per core
    pool_map_if map_if [POOL_CORE] ();

    // ==============================
    // Cores
    // ==============================
    for (genvar c = 0; c < POOL_CORE; c++) begin : g_core
        pool_core u_core (
            .clk               (clk),
            .rst_n             (rst_n),
            .cfg_valid         (cfg_valid[c]),
            .cfg_ready         (cfg_ready[c]),
            .cfg_k             (cfg_k[c*K_WIDTH +: K_WIDTH]),
            .cfg_nip           (cfg_nip[c*IDX_WIDTH +: IDX_WIDTH]),
            .cfg_chn_grp       (cfg_chn_grp[c*GRP_WIDTH +: GRP_WIDTH]),
            .cfg_map_base      (cfg_map_base[c*IDX_WIDTH +: IDX_WIDTH]),
            .cfg_out_base      (cfg_out_base[c*IDX_WIDTH +: IDX_WIDTH]),
            .map               (map_if[c]),
            .ofm_rd_addr       (ofm_rd_addr[c*IDX_WIDTH +: IDX_WIDTH]),
            .ofm_rd_addr_valid (ofm_rd_addr_valid[c]),
            .ofm_rd_addr_ready (ofm_rd_addr_ready[c]),
            .ofm_rd_data       (ofm_rd_data[c*FEAT_WIDTH +: FEAT_WIDTH]),
            .ofm_rd_valid      (ofm_rd_valid[c]),
            .ofm_rd_ready      (ofm_rd_ready[c]),
            .ofm_wr_addr       (ofm_wr_addr[c*IDX_WIDTH +: IDX_WIDTH]),
            .ofm_wr_data       (ofm_wr_data[c*FEAT_WIDTH +: FEAT_WIDTH]),
            .ofm_wr_valid      (ofm_wr_valid[c]),
            .ofm_wr_ready      (ofm_wr_ready[c])
        );
    end

    // Map port sharing
    pool_map_arbiter #(
        .POOL_CORE (POOL_CORE)
    ) u_arbiter (
        .clk            (clk),
        .rst_n          (rst_n),
        .map            (map_if),
        .map_addr       (map_addr),
        .map_addr_valid (map_addr_valid),
        .map_addr_ready (map_addr_ready),
        .map_rsp_valid  (map_rsp_valid),
        .map_rsp_data   (map_rsp_data)
    );

endmodule

`default_nettype wire
